/* src/exe_pkg.sv */
package exe_pkg;

    localparam int xlen      = 32;
    localparam int exe_fun_w = 5;

    // single-cycle alu functions
    localparam logic [exe_fun_w-1:0] alu_add    = 5'd0;
    localparam logic [exe_fun_w-1:0] alu_sub    = 5'd1;
    localparam logic [exe_fun_w-1:0] alu_and    = 5'd2;
    localparam logic [exe_fun_w-1:0] alu_or     = 5'd3;
    localparam logic [exe_fun_w-1:0] alu_xor    = 5'd4;
    localparam logic [exe_fun_w-1:0] alu_sll    = 5'd5;
    localparam logic [exe_fun_w-1:0] alu_srl    = 5'd6;
    localparam logic [exe_fun_w-1:0] alu_sra    = 5'd7;
    localparam logic [exe_fun_w-1:0] alu_slt    = 5'd8;
    localparam logic [exe_fun_w-1:0] alu_sltu   = 5'd9;
    localparam logic [exe_fun_w-1:0] alu_jalr   = 5'd10;
    localparam logic [exe_fun_w-1:0] alu_copy1  = 5'd11;

    // rv32m codes for the multicycle units
    localparam logic [exe_fun_w-1:0] alu_mul    = 5'd12;
    localparam logic [exe_fun_w-1:0] alu_mulh   = 5'd13;
    localparam logic [exe_fun_w-1:0] alu_mulhsu = 5'd14;
    localparam logic [exe_fun_w-1:0] alu_mulhu  = 5'd15;
    localparam logic [exe_fun_w-1:0] alu_div    = 5'd16;
    localparam logic [exe_fun_w-1:0] alu_divu   = 5'd17;
    localparam logic [exe_fun_w-1:0] alu_rem    = 5'd18;
    localparam logic [exe_fun_w-1:0] alu_remu   = 5'd19;

    localparam logic [exe_fun_w-1:0] br_beq     = 5'd20;
    localparam logic [exe_fun_w-1:0] br_bne     = 5'd21;
    localparam logic [exe_fun_w-1:0] br_blt     = 5'd22;
    localparam logic [exe_fun_w-1:0] br_bge     = 5'd23;
    localparam logic [exe_fun_w-1:0] br_bltu    = 5'd24;
    localparam logic [exe_fun_w-1:0] br_bgeu    = 5'd25;

endpackage

/* src/muldiv_pkg.sv */
package muldiv_pkg;

    localparam int half_w   = 32;
    localparam int res_w    = 2 * half_w;
    localparam int md_w     = half_w + 1;  // extra sign bit for s/u forms
    localparam int md_cnt_w = 6;

    // one 64-bit word, read as a product or as a divide result
    typedef union packed {
        struct packed {
            logic [half_w-1:0] hi;
            logic [half_w-1:0] lo;
        } prod;
        struct packed {
            logic [half_w-1:0] rem;
            logic [half_w-1:0] quo;
        } qr;
    } muldiv_result;

endpackage

/* src/alu_branch.sv */
module alu_branch (
    input  logic [exe_pkg::exe_fun_w-1:0] exe_fun,
    input  logic [exe_pkg::xlen-1:0]      op1_data,
    input  logic [exe_pkg::xlen-1:0]      op2_data,
    input  logic [exe_pkg::xlen-1:0]      pc,
    input  logic [exe_pkg::xlen-1:0]      imm_b,
    input  logic [exe_pkg::xlen-1:0]      imm_j,
    input  logic                          jmp_pc_flg,
    input  logic                          jmp_reg_flg,
    input  logic [exe_pkg::xlen-1:0]      held_result,
    output logic [exe_pkg::xlen-1:0]      alu_out,
    output logic                          br_taken,
    output logic [exe_pkg::xlen-1:0]      branch_target
);
    import exe_pkg::*;

    logic [xlen-1:0] sum;
    logic            lt_s;
    logic            lt_u;
    logic            eq;
    logic            br_cond;

    assign sum  = op1_data + op2_data;
    assign lt_s = $signed(op1_data) < $signed(op2_data);
    assign lt_u = op1_data < op2_data;
    assign eq   = op1_data == op2_data;

    always_comb begin
        case (exe_fun)
            alu_add:   alu_out = sum;
            alu_sub:   alu_out = op1_data - op2_data;
            alu_and:   alu_out = op1_data & op2_data;
            alu_or:    alu_out = op1_data | op2_data;
            alu_xor:   alu_out = op1_data ^ op2_data;
            alu_sll:   alu_out = op1_data << op2_data[4:0];
            alu_srl:   alu_out = op1_data >> op2_data[4:0];
            alu_sra:   alu_out = $unsigned($signed(op1_data) >>> op2_data[4:0]);
            alu_slt:   alu_out = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu:  alu_out = {{(xlen-1){1'b0}}, lt_u};
            alu_jalr:  alu_out = {sum[xlen-1:1], 1'b0};  // lsb cleared
            alu_copy1: alu_out = op1_data;
            alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
            alu_div, alu_divu, alu_rem, alu_remu:
                alu_out = held_result;  // from the multicycle units
            default:   alu_out = '0;
        endcase
    end

    always_comb begin
        case (exe_fun)
            br_beq:  br_cond = eq;
            br_bne:  br_cond = !eq;
            br_blt:  br_cond = lt_s;
            br_bge:  br_cond = !lt_s;
            br_bltu: br_cond = lt_u;
            br_bgeu: br_cond = !lt_u;
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken = jmp_pc_flg || jmp_reg_flg || br_cond;

    assign branch_target = jmp_pc_flg  ? pc + imm_j :
                           jmp_reg_flg ? sum :
                           pc + imm_b;

endmodule

/* src/div_unit.sv */
module div_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [muldiv_pkg::md_w-1:0]  dividend,
    input  logic [muldiv_pkg::md_w-1:0]  divisor,
    output logic                         ready,
    output logic                         done,
    output muldiv_pkg::muldiv_result     result
);
    import muldiv_pkg::*;

    logic                busy;
    logic [md_cnt_w-1:0] cnt;
    logic [md_w-1:0]     quo;   // dividend magnitude shifts out, quotient bits in
    logic [md_w-1:0]     rem;
    logic [md_w-1:0]     dmag;
    logic                q_neg;
    logic                r_neg;
    logic [md_w:0]       shifted;
    logic [md_w+1:0]     diff;
    logic                diff_neg;
    logic [md_w-1:0]     q_fix;
    logic [md_w-1:0]     r_fix;
    logic                zero_div;

    assign zero_div = divisor == '0;
    assign shifted  = {rem, quo[md_w-1]};
    assign diff     = {1'b0, shifted} - {2'b00, dmag};
    assign diff_neg = diff[md_w+1];
    assign q_fix    = q_neg ? -quo : quo;
    assign r_fix    = r_neg ? -rem : rem;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            ready <= 1'b1;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (start && ready) begin
                ready <= 1'b0;
                cnt   <= '0;
                if (zero_div)
                    done <= 1'b1;  // nothing to iterate
                else
                    busy <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == md_cnt_w'(md_w)) begin  // sign fix cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (done) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            quo   <= dividend[md_w-1] ? -dividend : dividend;
            dmag  <= divisor[md_w-1] ? -divisor : divisor;
            rem   <= '0;
            q_neg <= dividend[md_w-1] ^ divisor[md_w-1];
            r_neg <= dividend[md_w-1];
            if (zero_div) begin
                result.qr.quo <= '1;
                result.qr.rem <= dividend[half_w-1:0];
            end
        end else if (busy) begin
            if (cnt < md_cnt_w'(md_w)) begin
                rem <= diff_neg ? shifted[md_w-1:0] : diff[md_w-1:0];  // restore on borrow
                quo <= {quo[md_w-2:0], !diff_neg};
            end else begin
                result.qr.quo <= q_fix[half_w-1:0];
                result.qr.rem <= r_fix[half_w-1:0];
            end
        end
    end

endmodule

/* src/mul_unit.sv */
module mul_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [muldiv_pkg::md_w-1:0]  multiplicand,
    input  logic [muldiv_pkg::md_w-1:0]  multiplier,
    output logic                         ready,
    output logic                         done,
    output muldiv_pkg::muldiv_result     result
);
    import muldiv_pkg::*;

    logic                busy;
    logic [md_cnt_w-1:0] cnt;
    logic [2*md_w-1:0]   mcand_sh;  // sign-extended, shifts left each step
    logic [md_w-1:0]     mplier;
    logic [2*md_w-1:0]   acc;
    logic [2*md_w-1:0]   next_acc;
    logic                last;

    assign last = cnt == md_cnt_w'(md_w - 1);

    // msb of the multiplier has negative weight
    assign next_acc = !mplier[0] ? acc :
                      last       ? acc - mcand_sh :
                      acc + mcand_sh;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            ready <= 1'b1;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (start && ready) begin
                busy  <= 1'b1;
                ready <= 1'b0;
                cnt   <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (done) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            mcand_sh <= {{md_w{multiplicand[md_w-1]}}, multiplicand};
            mplier   <= multiplier;
            acc      <= '0;
        end else if (busy) begin
            mcand_sh <= mcand_sh << 1;
            mplier   <= mplier >> 1;
            acc      <= next_acc;
        end
    end

    assign result = acc[res_w-1:0];  // top two bits are sign only

endmodule

/* src/execute_stage.sv */
module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          exe_valid,
    input  logic [63:0]                   exe_inst_id,
    input  logic [exe_pkg::exe_fun_w-1:0] exe_fun,
    input  logic [exe_pkg::xlen-1:0]      op1_data,
    input  logic [exe_pkg::xlen-1:0]      op2_data,
    input  logic [exe_pkg::xlen-1:0]      imm_b,
    input  logic [exe_pkg::xlen-1:0]      imm_j,
    input  logic                          jmp_pc_flg,
    input  logic                          jmp_reg_flg,
    input  logic [exe_pkg::xlen-1:0]      pc,
    input  logic                          pipeline_flush,
    output logic                          mem_valid,
    output logic [exe_pkg::xlen-1:0]      alu_out,
    output logic                          branch_hazard,
    output logic [exe_pkg::xlen-1:0]      branch_target,
    output logic                          calc_stall
);
    import exe_pkg::*;
    import muldiv_pkg::*;

    logic            is_div;
    logic            is_mul;
    logic            calc_started;   // a unit is working for this stage
    logic            calc_finished;
    logic [63:0]     saved_inst_id;
    logic [xlen-1:0] held_result;
    logic            may_start;
    logic            can_start;
    logic            div_start;
    logic            mul_start;
    logic            div_ready;
    logic            mul_ready;
    logic            div_done;
    logic            mul_done;
    logic            div_signed;
    logic            mul_a_signed;
    logic            mul_b_signed;
    logic [md_w-1:0] div_a;
    logic [md_w-1:0] div_b;
    logic [md_w-1:0] mul_a;
    logic [md_w-1:0] mul_b;
    muldiv_result    div_res;
    muldiv_result    mul_res;
    muldiv_result    unit_res;
    logic            unit_done;
    logic            br_taken;

    assign is_div = exe_fun inside {alu_div, alu_divu, alu_rem, alu_remu};
    assign is_mul = exe_fun inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};

    assign div_signed   = exe_fun inside {alu_div, alu_rem};
    assign mul_a_signed = exe_fun inside {alu_mul, alu_mulh, alu_mulhsu};
    assign mul_b_signed = exe_fun inside {alu_mul, alu_mulh};  // op2 stays unsigned for mulhsu

    assign div_a = {div_signed && op1_data[xlen-1], op1_data};
    assign div_b = {div_signed && op2_data[xlen-1], op2_data};
    assign mul_a = {mul_a_signed && op1_data[xlen-1], op1_data};
    assign mul_b = {mul_b_signed && op2_data[xlen-1], op2_data};

    // same inst_id as the last finished one reuses the held result
    assign may_start = !(calc_finished && saved_inst_id == exe_inst_id);
    assign can_start = exe_valid && may_start && !calc_started && !pipeline_flush;
    assign div_start = can_start && is_div && div_ready;
    assign mul_start = can_start && is_mul && mul_ready;

    assign unit_done = is_div ? div_done : mul_done;
    assign unit_res  = is_div ? div_res : mul_res;

    assign calc_stall    = exe_valid && (is_div || is_mul) && may_start;
    assign mem_valid     = exe_valid && !calc_stall;
    assign branch_hazard = exe_valid && br_taken;

    always_ff @(posedge clk) begin
        if (reset || pipeline_flush) begin
            calc_started  <= 1'b0;
            calc_finished <= 1'b0;
        end else if (div_start || mul_start) begin
            calc_started  <= 1'b1;
            calc_finished <= 1'b0;
        end else if (calc_started && unit_done) begin
            calc_started  <= 1'b0;
            calc_finished <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (calc_started && unit_done && !pipeline_flush) begin
            saved_inst_id <= exe_inst_id;
            case (exe_fun)
                alu_mul:                        held_result <= unit_res.prod.lo;
                alu_mulh, alu_mulhsu, alu_mulhu: held_result <= unit_res.prod.hi;
                alu_div, alu_divu:              held_result <= unit_res.qr.quo;
                default:                        held_result <= unit_res.qr.rem;
            endcase
        end
    end

    alu_branch u_alu_branch (
        .exe_fun       (exe_fun),
        .op1_data      (op1_data),
        .op2_data      (op2_data),
        .pc            (pc),
        .imm_b         (imm_b),
        .imm_j         (imm_j),
        .jmp_pc_flg    (jmp_pc_flg),
        .jmp_reg_flg   (jmp_reg_flg),
        .held_result   (held_result),
        .alu_out       (alu_out),
        .br_taken      (br_taken),
        .branch_target (branch_target)
    );

    div_unit u_div_unit (
        .clk      (clk),
        .reset    (reset),
        .start    (div_start),
        .dividend (div_a),
        .divisor  (div_b),
        .ready    (div_ready),
        .done     (div_done),
        .result   (div_res)
    );

    mul_unit u_mul_unit (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (mul_a),
        .multiplier   (mul_b),
        .ready        (mul_ready),
        .done         (mul_done),
        .result       (mul_res)
    );

endmodule

/* verification/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #50 clk = !clk;  // 100 ns period
    end

    initial begin
        repeat (3) @(posedge clk);
        #10 reset = 1'b0;  // released just after the third edge
    end

endmodule

/* verification/execute_stage_asserts.sv */
module execute_stage_asserts (
    input logic                          clk,
    input logic                          reset,
    input logic                          calc_stall,
    input logic                          mem_valid,
    input logic                          unit_done,
    input logic                          pipeline_flush,
    input logic [exe_pkg::exe_fun_w-1:0] exe_fun
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled instruction retires only once its unit is done
    retire_after_done: assert property (@(posedge clk) disable iff (reset)
        (mem_valid && $past(calc_stall)) |-> $past(unit_done))
        else $error("mem_valid rose after a stall without a unit done");

    stall_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !calc_stall)
        else $error("calc_stall is high right after reset");

    // upstream holds the instruction unless it is flushed
    held_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (calc_stall && !pipeline_flush) |=> $stable(exe_fun))
        else $error("exe_fun changed while calc_stall was high");

endmodule

bind execute_stage execute_stage_asserts u_asserts (.*);

/* verification/execute_stage_tb.sv */
module execute_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exe_pkg::*;

    logic                 clk;
    logic                 reset;
    logic                 exe_valid;
    logic [63:0]          exe_inst_id;
    logic [exe_fun_w-1:0] exe_fun;
    logic [xlen-1:0]      op1_data;
    logic [xlen-1:0]      op2_data;
    logic [xlen-1:0]      imm_b;
    logic [xlen-1:0]      imm_j;
    logic                 jmp_pc_flg;
    logic                 jmp_reg_flg;
    logic [xlen-1:0]      pc;
    logic                 pipeline_flush;
    logic                 mem_valid;
    logic [xlen-1:0]      alu_out;
    logic                 branch_hazard;
    logic [xlen-1:0]      branch_target;
    logic                 calc_stall;
    int                   seed;
    int                   n_issued;
    int                   n_compared;
    logic [63:0]          cur_id;
    logic [exe_fun_w-1:0] single_codes [12] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, alu_jalr, alu_copy1};
    logic [exe_fun_w-1:0] branch_codes [6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    logic [exe_fun_w-1:0] muldiv_codes [8] = '{alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
        alu_div, alu_divu, alu_rem, alu_remu};
    logic [xlen-1:0]      corners [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h1,
        32'h7fff_ffff};

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    execute_stage UUT (.*);

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    // rv32im result, branch decision and target
    function automatic void ref_exe(input logic [exe_fun_w-1:0] fun, input logic [31:0] a,
        input logic [31:0] b, input logic [31:0] p, input logic [31:0] ib, input logic [31:0] ij,
        input logic jp, input logic jr,
        output logic [31:0] res, output logic taken, output logic [31:0] target);
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        logic        cond;
        p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        p_su = {{32{a[31]}}, a} * {32'b0, b};
        p_uu = {32'b0, a} * {32'b0, b};
        res  = '0;
        cond = 1'b0;
        case (fun)
            alu_add:    res = a + b;
            alu_sub:    res = a - b;
            alu_and:    res = a & b;
            alu_or:     res = a | b;
            alu_xor:    res = a ^ b;
            alu_sll:    res = a << b[4:0];
            alu_srl:    res = a >> b[4:0];
            alu_sra:    res = $signed(a) >>> b[4:0];
            alu_slt:    res = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   res = {31'b0, a < b};
            alu_jalr:   res = (a + b) & ~32'd1;
            alu_copy1:  res = a;
            alu_mul:    res = p_uu[31:0];
            alu_mulh:   res = p_ss[63:32];
            alu_mulhsu: res = p_su[63:32];
            alu_mulhu:  res = p_uu[63:32];
            alu_div, alu_rem: begin
                if (b == 0)
                    res = (fun == alu_div) ? 32'hffff_ffff : a;
                else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                    res = (fun == alu_div) ? a : 32'h0;  // signed overflow
                else
                    res = (fun == alu_div) ? $signed(a) / $signed(b) : $signed(a) % $signed(b);
            end
            alu_divu, alu_remu: begin
                if (b == 0)
                    res = (fun == alu_divu) ? 32'hffff_ffff : a;
                else
                    res = (fun == alu_divu) ? a / b : a % b;
            end
            br_beq:     cond = a == b;
            br_bne:     cond = a != b;
            br_blt:     cond = $signed(a) < $signed(b);
            br_bge:     cond = $signed(a) >= $signed(b);
            br_bltu:    cond = a < b;
            br_bgeu:    cond = a >= b;
            default:    res = '0;
        endcase
        taken  = jp || jr || cond;
        target = jp ? p + ij : jr ? a + b : p + ib;
    endfunction

    always @(posedge clk) begin
        logic [xlen-1:0] exp_out;
        logic            exp_taken;
        logic [xlen-1:0] exp_target;
        if (mem_valid) begin
            ref_exe(exe_fun, op1_data, op2_data, pc, imm_b, imm_j, jmp_pc_flg, jmp_reg_flg,
                exp_out, exp_taken, exp_target);
            if (!(exe_fun inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu}))
                check_value("alu_out", alu_out, exp_out);
            check_value("branch_hazard", branch_hazard, exp_taken);
            check_value("branch_target", branch_target, exp_target);
            n_compared++;
        end
    end

    // drive one instruction and wait until it retires
    task automatic issue(input logic [exe_fun_w-1:0] fun, input logic [xlen-1:0] a,
        input logic [xlen-1:0] b, input logic jp, input logic jr, input logic reuse);
        int   waited;
        logic quick;
        quick = reuse || !(fun inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
            alu_div, alu_divu, alu_rem, alu_remu});
        if (!reuse)
            cur_id = cur_id + 1;
        exe_valid   = 1'b1;
        exe_inst_id = cur_id;
        exe_fun     = fun;
        op1_data    = a;
        op2_data    = b;
        jmp_pc_flg  = jp;
        jmp_reg_flg = jr;
        pc          = $random(seed);
        imm_b       = $random(seed);
        imm_j       = $random(seed);
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 100)
                stop_on_error("calc_stall did not fall within 100 cycles");
        end while (calc_stall);
        check_value("mem_valid", mem_valid, 1'b1);
        if (quick)
            check_value("cycles to retire", waited, 1);  // no stall expected
        n_issued++;
        #10;
    endtask

    initial begin
        int waited;
        seed           = 32'hb5c3;
        n_issued       = 0;
        n_compared     = 0;
        cur_id         = '0;
        exe_valid      = 1'b0;
        exe_inst_id    = '0;
        exe_fun        = alu_add;
        op1_data       = '0;
        op2_data       = '0;
        imm_b          = '0;
        imm_j          = '0;
        jmp_pc_flg     = 1'b0;
        jmp_reg_flg    = 1'b0;
        pc             = '0;
        pipeline_flush = 1'b0;
        waited         = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 20)
                stop_on_error("reset was not released within 20 cycles");
        end while (reset);
        #10;

        foreach (single_codes[i])
            repeat (4)
                issue(single_codes[i], $random(seed), $random(seed), 1'b0,
                    single_codes[i] == alu_jalr, 1'b0);

        // equal, signed-less/unsigned-greater, the reverse, then random
        foreach (branch_codes[i]) begin
            issue(branch_codes[i], 32'h0000_1234, 32'h0000_1234, 1'b0, 1'b0, 1'b0);
            issue(branch_codes[i], 32'hffff_fff0, 32'h0000_0010, 1'b0, 1'b0, 1'b0);
            issue(branch_codes[i], 32'h0000_0010, 32'hffff_fff0, 1'b0, 1'b0, 1'b0);
            issue(branch_codes[i], $random(seed), $random(seed), 1'b0, 1'b0, 1'b0);
        end
        issue(alu_copy1, $random(seed), $random(seed), 1'b1, 1'b0, 1'b0);  // jal
        issue(alu_jalr, $random(seed), $random(seed), 1'b0, 1'b1, 1'b0);

        foreach (muldiv_codes[i]) begin
            foreach (corners[j])
                foreach (corners[k])
                    issue(muldiv_codes[i], corners[j], corners[k], 1'b0, 1'b0, 1'b0);
            repeat (6)
                issue(muldiv_codes[i], $random(seed), $random(seed), 1'b0, 1'b0, 1'b0);
        end

        issue(alu_mulh, 32'h8765_4321, 32'h1234_5678, 1'b0, 1'b0, 1'b0);
        issue(alu_mulh, 32'h8765_4321, 32'h1234_5678, 1'b0, 1'b0, 1'b1);  // same inst_id

        // divide cut short by a flush
        cur_id      = cur_id + 1;
        exe_inst_id = cur_id;
        exe_fun     = alu_div;
        op1_data    = 32'd1000;
        op2_data    = 32'd7;
        jmp_pc_flg  = 1'b0;
        jmp_reg_flg = 1'b0;
        repeat (10) @(posedge clk);
        check_value("calc_stall", calc_stall, 1'b1);
        #10 pipeline_flush = 1'b1;
        @(posedge clk);
        #10 pipeline_flush = 1'b0;
        issue(alu_mul, 32'hfffe_1234, 32'h0003_0007, 1'b0, 1'b0, 1'b0);

        exe_valid = 1'b0;
        @(posedge clk);
        if (n_compared != n_issued)
            stop_on_error($sformatf("%0d results retired for %0d instructions",
                n_compared, n_issued));
        else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* sources.f */
src/exe_pkg.sv
src/muldiv_pkg.sv
src/alu_branch.sv
src/div_unit.sv
src/mul_unit.sv
src/execute_stage.sv
verification/clock_gen.sv
verification/execute_stage_asserts.sv
verification/execute_stage_tb.sv

/* Makefile */
TOP = execute_stage_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
